/* lsu_pkg.sv */
// shared sizes and types for the store path of the load/store unit.
package lsu_pkg;

    // number of store buffer entries and the width of its pointers.
    localparam int unsigned SB_SIZE  = 4;
    localparam int unsigned SB_PTR_W = 2;

    // the data RAM holds 64 words, indexed by byte address bits 7 down to 2.
    localparam int unsigned RAM_WORDS = 64;
    localparam int unsigned RAM_IDX_W = $clog2(RAM_WORDS);

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = 4;

    // one buffered store takes 69 bits.
    // valid marks an occupied slot inside the buffer.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              valid;
    } sb_entry_t;

    // a load request carries only its byte address.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } load_req_t;

    // a load response carries the merged word.
    typedef struct packed {
        logic [DATA_W-1:0] data;
    } load_resp_t;

    // what the single RAM port does in a given cycle.
    typedef enum logic [1:0] {
        RAM_IDLE  = 2'd0,
        RAM_READ  = 2'd1,
        RAM_DRAIN = 2'd2
    } ram_op_e;

endpackage

/* store_buffer.sv */
`timescale 1ns/1ps

// circular store buffer.
// stores enter at the head and drain from the tail, oldest first.
module store_buffer (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          flush,
    input  logic                                          store_valid,
    input  lsu_pkg::sb_entry_t                            store,
    output logic                                          store_ready,
    output logic                                          drain_valid,
    output lsu_pkg::sb_entry_t                            drain,
    input  logic                                          drain_ready,
    output lsu_pkg::sb_entry_t [lsu_pkg::SB_SIZE-1:0]     sb_entries,
    output logic [lsu_pkg::SB_PTR_W-1:0]                  sb_oldest
);

    lsu_pkg::sb_entry_t [lsu_pkg::SB_SIZE-1:0] entries;
    lsu_pkg::sb_entry_t                        store_in;

    logic [lsu_pkg::SB_PTR_W-1:0] head;
    logic [lsu_pkg::SB_PTR_W-1:0] tail;
    logic [lsu_pkg::SB_PTR_W:0]   count;

    logic push;
    logic pop;

    // a store presented together with flush is dropped.
    assign push = store_valid && store_ready && !flush;
    assign pop  = drain_valid && drain_ready;

    // the slot is marked occupied no matter what the source put in valid.
    always_comb begin
        store_in       = store;
        store_in.valid = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + (lsu_pkg::SB_PTR_W)'(push);
            tail  <= tail + (lsu_pkg::SB_PTR_W)'(pop);
            count <= count + (lsu_pkg::SB_PTR_W + 1)'(push) - (lsu_pkg::SB_PTR_W + 1)'(pop);
        end
    end

    // push and pop never hit the same slot.
    // an empty buffer has no valid tail and a full one accepts nothing.
    always_ff @(posedge clk) begin
        for (int i = 0; i < lsu_pkg::SB_SIZE; i++) begin
            if (!rst_n || flush) begin
                entries[i] <= '0;
            end else if (push && (i[lsu_pkg::SB_PTR_W-1:0] == head)) begin
                entries[i] <= store_in;
            end else if (pop && (i[lsu_pkg::SB_PTR_W-1:0] == tail)) begin
                entries[i].valid <= 1'b0;
            end
        end
    end

    assign store_ready = (count < (lsu_pkg::SB_PTR_W + 1)'(lsu_pkg::SB_SIZE));
    assign drain       = entries[tail];
    assign drain_valid = entries[tail].valid;
    assign sb_entries  = entries;
    assign sb_oldest   = tail;

    // a full buffer stays full until something drains or a flush comes.
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (count == lsu_pkg::SB_SIZE) && !pop && !flush |=> (count == lsu_pkg::SB_SIZE)
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= lsu_pkg::SB_SIZE
    );

    // the oldest slot holds a store exactly when the count says so.
    a_tail_matches_count: assert property (
        @(posedge clk) disable iff (!rst_n)
        drain_valid == (count != '0)
    );

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

// single-port word RAM shared by loads and store buffer drains.
// a load read always wins the port.
module data_ram (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_valid,
    input  lsu_pkg::load_req_t          load,
    input  logic                        drain_valid,
    input  lsu_pkg::sb_entry_t          drain,
    output logic                        drain_ready,
    output logic [lsu_pkg::DATA_W-1:0]  rdata
);

    logic [lsu_pkg::DATA_W-1:0] mem [lsu_pkg::RAM_WORDS];

    lsu_pkg::ram_op_e op;

    logic [lsu_pkg::RAM_IDX_W-1:0] rd_idx;
    logic [lsu_pkg::RAM_IDX_W-1:0] wr_idx;

    // the contents start out as zero.
    initial begin
        for (int i = 0; i < lsu_pkg::RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        if (load_valid) begin
            op = lsu_pkg::RAM_READ;
        end else if (drain_valid) begin
            op = lsu_pkg::RAM_DRAIN;
        end else begin
            op = lsu_pkg::RAM_IDLE;
        end
    end

    assign drain_ready = !load_valid;

    // word index from byte address bits 7 down to 2.
    assign rd_idx = load.addr[lsu_pkg::RAM_IDX_W+1:2];
    assign wr_idx = drain.addr[lsu_pkg::RAM_IDX_W+1:2];

    // only the strobed bytes of a drained store are written.
    always_ff @(posedge clk) begin
        if (op == lsu_pkg::RAM_DRAIN) begin
            for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
                if (drain.strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= drain.data[8*b +: 8];
                end
            end
        end
    end

    // read data shows up one cycle after the request.
    always_ff @(posedge clk) begin
        if (op == lsu_pkg::RAM_READ) begin
            rdata <= mem[rd_idx];
        end
    end

    // an entry the buffer pops is written in that same cycle, never during a load read.
    a_read_blocks_drain: assert property (
        @(posedge clk) disable iff (!rst_n)
        (drain_valid && drain_ready) |-> !load_valid && (op == lsu_pkg::RAM_DRAIN)
    );

endmodule

/* load_merge.sv */
`timescale 1ns/1ps

// forwards buffered store bytes into a load response.
// the buffer snapshot is taken in the load cycle and merged with the RAM
// word when it arrives one cycle later.
module load_merge (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       load_valid,
    input  lsu_pkg::load_req_t                         load,
    input  lsu_pkg::sb_entry_t [lsu_pkg::SB_SIZE-1:0]  sb_entries,
    input  logic [lsu_pkg::SB_PTR_W-1:0]               sb_oldest,
    input  logic [lsu_pkg::DATA_W-1:0]                 rdata,
    output logic                                       resp_valid,
    output lsu_pkg::load_resp_t                        resp
);

    logic [lsu_pkg::DATA_W-1:0] fwd_data;
    logic [lsu_pkg::STRB_W-1:0] fwd_mask;
    logic [lsu_pkg::DATA_W-1:0] fwd_data_q;
    logic [lsu_pkg::STRB_W-1:0] fwd_mask_q;

    // walk from oldest to youngest so that younger stores overwrite
    // older ones byte by byte.
    always_comb begin
        logic [lsu_pkg::SB_PTR_W-1:0] idx;
        logic                         hit;

        fwd_data = '0;
        fwd_mask = '0;
        for (int k = 0; k < lsu_pkg::SB_SIZE; k++) begin
            idx = sb_oldest + k[lsu_pkg::SB_PTR_W-1:0];
            hit = sb_entries[idx].valid &&
                  (sb_entries[idx].addr[lsu_pkg::ADDR_W-1:2] == load.addr[lsu_pkg::ADDR_W-1:2]);
            for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
                if (hit && sb_entries[idx].strb[b]) begin
                    fwd_data[8*b +: 8] = sb_entries[idx].data[8*b +: 8];
                    fwd_mask[b]        = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= load_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            fwd_data_q <= fwd_data;
            fwd_mask_q <= fwd_mask;
        end
    end

    // forwarded bytes take precedence over the RAM word.
    always_comb begin
        for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
            if (fwd_mask_q[b]) begin
                resp.data[8*b +: 8] = fwd_data_q[8*b +: 8];
            end else begin
                resp.data[8*b +: 8] = rdata[8*b +: 8];
            end
        end
    end

endmodule

/* lsu_top.sv */
`timescale 1ns/1ps

// store path of the load/store unit.
// the buffer drains into the RAM while loads merge both views.
module lsu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                store_valid,
    output logic                store_ready,
    input  lsu_pkg::sb_entry_t  store,
    input  logic                load_valid,
    input  lsu_pkg::load_req_t  load,
    output logic                resp_valid,
    output lsu_pkg::load_resp_t resp
);

    logic                                      drain_valid;
    logic                                      drain_ready;
    lsu_pkg::sb_entry_t                        drain;
    lsu_pkg::sb_entry_t [lsu_pkg::SB_SIZE-1:0] sb_entries;
    logic [lsu_pkg::SB_PTR_W-1:0]              sb_oldest;
    logic [lsu_pkg::DATA_W-1:0]                rdata;

    store_buffer u_store_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .store_valid (store_valid),
        .store       (store),
        .store_ready (store_ready),
        .drain_valid (drain_valid),
        .drain       (drain),
        .drain_ready (drain_ready),
        .sb_entries  (sb_entries),
        .sb_oldest   (sb_oldest)
    );

    data_ram u_data_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load        (load),
        .drain_valid (drain_valid),
        .drain       (drain),
        .drain_ready (drain_ready),
        .rdata       (rdata)
    );

    // the snapshot here sees the same buffer state the RAM read does,
    // since a drain cannot happen in a load cycle.
    load_merge u_load_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load       (load),
        .sb_entries (sb_entries),
        .sb_oldest  (sb_oldest),
        .rdata      (rdata),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

/* tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;

    logic                clk;
    logic                rst_n;
    logic                flush;
    logic                store_valid;
    logic                store_ready;
    lsu_pkg::sb_entry_t  store;
    logic                load_valid;
    lsu_pkg::load_req_t  load;
    logic                resp_valid;
    lsu_pkg::load_resp_t resp;

    // reference model of the RAM bytes and of the stores not yet drained.
    logic [7:0]         model_mem [lsu_pkg::RAM_WORDS*4];
    lsu_pkg::sb_entry_t model_q [$];
    int                 queue_len;
    logic [31:0]        exp_pending;
    logic [31:0]        exp_data;
    logic [31:0]        resp_seen;
    string              test_name;
    string              name_pending;
    string              name_now;

    logic [31:0] lfsr = 32'hefe914cd;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          directed_len = 100;
    int          random_len = 400;

    lsu_top u_lsu_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store       (store),
        .load_valid  (load_valid),
        .load        (load),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    always #10 clk = ~clk;

    a_resp_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid == $past(load_valid)
    ) else begin
        other_count++;
        $display("resp_valid did not follow load_valid by exactly one cycle");
    end

    // exp_data and resp_seen stay put from the negedge before this check until after it.
    a_resp_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid |-> (resp.data == exp_data)
    ) else begin
        mismatch_count++;
        $display("mismatch %s expected %08h actual %08h", name_now, exp_data, resp_seen);
    end

    a_ready_when_room: assert property (
        @(negedge clk) disable iff (!rst_n)
        (queue_len < lsu_pkg::SB_SIZE) |-> store_ready
    ) else begin
        other_count++;
        $display("store_ready is low although the buffer has room");
    end

    a_not_ready_when_full: assert property (
        @(negedge clk) disable iff (!rst_n)
        (queue_len == lsu_pkg::SB_SIZE) |-> !store_ready
    ) else begin
        other_count++;
        $display("store_ready is high although the buffer is full");
    end

    // the galois lfsr is stepped once for every bit handed out.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        out;
        r = '0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = (lfsr >> 1) ^ (out ? 32'h80200003 : 32'h0);
            r    = {r[30:0], out};
        end
        return r;
    endfunction

    function automatic lsu_pkg::sb_entry_t make_store(input logic [31:0] addr,
                                                      input logic [31:0] data,
                                                      input logic [3:0]  strb);
        lsu_pkg::sb_entry_t s;
        s.addr  = addr;
        s.data  = data;
        s.strb  = strb;
        s.valid = 1'b1;
        return s;
    endfunction

    // addresses stay within eight words so that stores and loads collide often.
    function automatic logic [31:0] rand_addr();
        return rand_bits(3) << 2;
    endfunction

    function automatic lsu_pkg::sb_entry_t random_store();
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        a = rand_addr();
        d = rand_bits(32);
        s = rand_bits(4);
        return make_store(a, d, s);
    endfunction

    // memory word with every queued store laid over it in acceptance order.
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [31:0] w;
        int          base;
        base = int'(addr[lsu_pkg::RAM_IDX_W+1:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model_mem[base + b];
        end
        foreach (model_q[i]) begin
            for (int b = 0; b < 4; b++) begin
                if (model_q[i].addr[31:2] == addr[31:2] && model_q[i].strb[b]) begin
                    w[8*b +: 8] = model_q[i].data[8*b +: 8];
                end
            end
        end
        return w;
    endfunction

    // the model steps at the negedge, where inputs and store_ready are settled.
    always @(negedge clk) begin
        lsu_pkg::sb_entry_t e;
        int                 base;
        resp_seen = resp.data;
        exp_data  = exp_pending;
        name_now  = name_pending;
        if (!rst_n) begin
            model_q.delete();
        end else begin
            if (load_valid) begin
                exp_pending  = model_word(load.addr);
                name_pending = test_name;
            end
            if (!load_valid && model_q.size() > 0) begin
                e    = model_q.pop_front();
                base = int'(e.addr[lsu_pkg::RAM_IDX_W+1:2]) * 4;
                for (int b = 0; b < 4; b++) begin
                    if (e.strb[b]) begin
                        model_mem[base + b] = e.data[8*b +: 8];
                    end
                end
            end
            if (flush) begin
                model_q.delete();
            end else if (store_valid && store_ready) begin
                model_q.push_back(store);
            end
        end
        queue_len = model_q.size();
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic run_cycle(input logic st_v, input lsu_pkg::sb_entry_t st,
                             input logic ld_v, input logic [31:0] ld_addr, input logic fl);
        store_valid = st_v;
        store       = st;
        load_valid  = ld_v;
        load.addr   = ld_addr;
        flush       = fl;
        tick();
    endtask

    task automatic settle(input int n);
        for (int i = 0; i < n; i++) begin
            run_cycle(1'b0, '0, 1'b0, 32'h0, 1'b0);
        end
    endtask

    // holds one store valid, without loads, until the buffer takes it.
    task automatic offer_until_taken(input lsu_pkg::sb_entry_t s);
        logic taken;
        taken = 1'b0;
        for (int i = 0; i < 8 && !taken; i++) begin
            taken = store_ready;
            run_cycle(1'b1, s, 1'b0, 32'h0, 1'b0);
        end
        assert (taken) else begin
            other_count++;
            $display("a held store was never accepted after loads stopped");
        end
    endtask

    task automatic drain_to_ram();
        test_name = "drain_to_ram";
        settle(6);
        run_cycle(1'b1, make_store(32'h10, 32'ha1b2c3d4, 4'hf), 1'b0, 32'h0, 1'b0);
        settle(3);
        run_cycle(1'b0, '0, 1'b1, 32'h10, 1'b0);
        settle(3);
    endtask

    task automatic forward_from_buffer();
        test_name = "forward_from_buffer";
        settle(6);
        run_cycle(1'b1, make_store(32'h10, 32'h55667788, 4'b0101), 1'b0, 32'h0, 1'b0);
        run_cycle(1'b0, '0, 1'b1, 32'h10, 1'b0);
        settle(3);
    endtask

    // loads every cycle keep the three stores parked in the buffer.
    task automatic merge_bytes();
        test_name = "merge_bytes";
        settle(6);
        run_cycle(1'b1, make_store(32'h14, 32'h0a0b0c0d, 4'b0011), 1'b1, 32'h14, 1'b0);
        run_cycle(1'b1, make_store(32'h14, 32'h1a1b1c1d, 4'b0110), 1'b1, 32'h14, 1'b0);
        run_cycle(1'b1, make_store(32'h14, 32'h2a2b2c2d, 4'b1100), 1'b1, 32'h14, 1'b0);
        run_cycle(1'b0, '0, 1'b1, 32'h14, 1'b0);
        settle(3);
    endtask

    task automatic apply_backpressure();
        lsu_pkg::sb_entry_t s;
        logic               taken;
        int                 sent;
        test_name = "backpressure";
        settle(6);
        s    = random_store();
        sent = 0;
        for (int c = 0; c < 10; c++) begin
            taken = store_ready;
            run_cycle(1'b1, s, 1'b1, rand_addr(), 1'b0);
            if (taken) begin
                sent++;
                s = random_store();
            end
        end
        assert (!store_ready && sent == lsu_pkg::SB_SIZE) else begin
            other_count++;
            $display("store_ready did not drop after %0d stores, %0d were taken",
                     lsu_pkg::SB_SIZE, sent);
        end
        offer_until_taken(s);
        settle(6);
    endtask

    task automatic flush_buffer();
        test_name = "flush_buffer";
        settle(6);
        run_cycle(1'b1, make_store(32'h18, 32'hdeadbeef, 4'hf), 1'b1, 32'h18, 1'b0);
        run_cycle(1'b1, make_store(32'h18, 32'h01020304, 4'b1001), 1'b1, 32'h18, 1'b0);
        run_cycle(1'b1, make_store(32'h1c, 32'hcafef00d, 4'hf), 1'b1, 32'h18, 1'b0);
        run_cycle(1'b0, '0, 1'b1, 32'h1c, 1'b1);
        settle(3);
        run_cycle(1'b0, '0, 1'b1, 32'h18, 1'b0);
        run_cycle(1'b0, '0, 1'b1, 32'h1c, 1'b0);
        settle(3);
    endtask

    task automatic random_mix(input int cycles);
        lsu_pkg::sb_entry_t s;
        logic               st_v;
        logic               ld_v;
        logic               fl;
        logic               taken;
        test_name = "random_mix";
        st_v = 1'b0;
        s    = '0;
        for (int c = 0; c < cycles; c++) begin
            if (!st_v && rand_bits(1) == 1) begin
                s    = random_store();
                st_v = 1'b1;
            end
            ld_v  = rand_bits(1);
            fl    = (rand_bits(5) == 0);
            taken = st_v && store_ready && !fl;
            run_cycle(st_v, s, ld_v, rand_addr(), fl);
            if (taken) begin
                st_v = 1'b0;
            end
        end
        if (st_v) begin
            offer_until_taken(s);
        end
        settle(6);
    endtask

    task automatic print_summary();
        $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
    endtask

    initial begin
        int limit_ns;
        limit_ns = (3 + directed_len + random_len + 50) * 20;
        #(limit_ns);
        other_count++;
        $display("timeout: the run was still going after %0d ns", limit_ns);
        print_summary();
        $display("** FAIL **");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        store_valid  = 1'b0;
        store        = '0;
        load_valid   = 1'b0;
        load         = '0;
        queue_len    = 0;
        exp_pending  = '0;
        exp_data     = '0;
        resp_seen    = '0;
        test_name    = "reset";
        name_pending = "reset";
        name_now     = "reset";
        for (int i = 0; i < lsu_pkg::RAM_WORDS * 4; i++) begin
            model_mem[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (store_ready) else begin
            other_count++;
            $display("store_ready is low right after reset");
        end
        drain_to_ram();
        forward_from_buffer();
        merge_bytes();
        apply_backpressure();
        flush_buffer();
        random_mix(random_len);
        print_summary();
        if (mismatch_count == 0 && other_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
lsu_pkg.sv
store_buffer.sv
data_ram.sv
load_merge.sv
lsu_top.sv
tb_lsu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f list.f -o tb_lsu
./obj_dir/tb_lsu | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
